// File: source/phy_defs.svh
`ifndef PHY_DEFS_SVH
`define PHY_DEFS_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////

// MAC byte, HGFEDCBA
`define PHY_DATA_W 8

// Code symbol, abcdei in bits 9..4 and fghj in bits 3..0
`define PHY_SYM_W 10

////////////////////////////////////////////////////////////
// Comma
////////////////////////////////////////////////////////////

// Consecutive commas before the receiver calls itself aligned
`define PHY_COMMA_COUNT 4

// K28.5 as a byte, sent with the K flag
`define PHY_K28_5 8'hBC

// K28.5 symbols for each starting disparity
`define PHY_COMMA_RDN 10'b0011111010
`define PHY_COMMA_RDP 10'b1100000101

`endif

// File: source/phy_pkg.sv
`default_nettype none

package phy_pkg;

  ////////////////////////////////////////////////////////////
  // PIPE receive status
  ////////////////////////////////////////////////////////////

  // Only the codes this PCS can raise
  // SKP add/remove and buffer codes belong to the elastic buffer
  typedef enum logic [2:0] {
    // Good symbol
    rx_ok         = 3'b000,
    // Not a valid 10b code
    rx_decode_err = 3'b100,
    // Valid code seen with the wrong running disparity
    rx_disp_err   = 3'b111
  } rx_status_t;

endpackage

`default_nettype wire

// File: source/enc_8b10b.sv
`default_nettype none

`include "phy_defs.svh"

module enc_8b10b (
  input  logic                  pclk,
  input  logic                  rst,
  input  logic [`PHY_DATA_W-1:0] tx_data,
  input  logic                  tx_datak,
  input  logic                  tx_en,
  output logic [`PHY_SYM_W-1:0]  tx_symbol
);

  // Disparity tx_symbol was coded with, 1 means positive
  logic                   rd_cur;
  // Disparity the next symbol starts from
  logic                   rd_in;
  // Disparity between the 6b and 4b parts
  logic                   rd_mid;
  logic [`PHY_DATA_W-1:0] byte_in;
  logic                   k_in;
  logic [4:0]             x5;
  logic [2:0]             y3;
  logic                   k28;
  logic                   kx7;
  logic                   alt7;
  logic                   flip4;
  logic [5:0]             code6_n;
  logic [5:0]             code6;
  logic [3:0]             code4_n;
  logic [3:0]             code4;

  // Unbalanced halves of the last symbol flip the disparity
  assign rd_in = rd_cur ^ ($countones(tx_symbol[9:4]) != 3) ^ ($countones(tx_symbol[3:0]) != 2);

  // Idle line carries K28.5
  assign byte_in = tx_en ? tx_data : `PHY_K28_5;
  assign k_in    = tx_en ? tx_datak : 1'b1;
  assign x5      = byte_in[4:0];
  assign y3      = byte_in[7:5];

  // Only the twelve legal K codes; any other byte goes out as data
  assign k28 = k_in && (x5 == 5'd28);
  assign kx7 = k_in && (y3 == 3'd7) && (x5 inside {5'd23, 5'd27, 5'd29, 5'd30});

  ////////////////////////////////////////////////////////////
  // 5b/6b
  ////////////////////////////////////////////////////////////

  // Codes for negative disparity, abcdei
  always_comb begin
    case (x5)
      5'd0:    code6_n = 6'b100111;
      5'd1:    code6_n = 6'b011101;
      5'd2:    code6_n = 6'b101101;
      5'd3:    code6_n = 6'b110001;
      5'd4:    code6_n = 6'b110101;
      5'd5:    code6_n = 6'b101001;
      5'd6:    code6_n = 6'b011001;
      5'd7:    code6_n = 6'b111000;
      5'd8:    code6_n = 6'b111001;
      5'd9:    code6_n = 6'b100101;
      5'd10:   code6_n = 6'b010101;
      5'd11:   code6_n = 6'b110100;
      5'd12:   code6_n = 6'b001101;
      5'd13:   code6_n = 6'b101100;
      5'd14:   code6_n = 6'b011100;
      5'd15:   code6_n = 6'b010111;
      5'd16:   code6_n = 6'b011011;
      5'd17:   code6_n = 6'b100011;
      5'd18:   code6_n = 6'b010011;
      5'd19:   code6_n = 6'b110010;
      5'd20:   code6_n = 6'b001011;
      5'd21:   code6_n = 6'b101010;
      5'd22:   code6_n = 6'b011010;
      5'd23:   code6_n = 6'b111010;
      5'd24:   code6_n = 6'b110011;
      5'd25:   code6_n = 6'b100110;
      5'd26:   code6_n = 6'b010110;
      5'd27:   code6_n = 6'b110110;
      5'd28:   code6_n = k28 ? 6'b001111 : 6'b001110;
      5'd29:   code6_n = 6'b101110;
      5'd30:   code6_n = 6'b011110;
      default: code6_n = 6'b101011;
    endcase
  end

  // Unbalanced codes and D.7 swap to the complement at positive disparity
  assign code6  = (rd_in && (($countones(code6_n) != 3) || (code6_n == 6'b111000))) ?
                  ~code6_n : code6_n;
  assign rd_mid = ($countones(code6) == 3) ? rd_in : ($countones(code6) > 3);

  ////////////////////////////////////////////////////////////
  // 3b/4b
  ////////////////////////////////////////////////////////////

  // A7 avoids a run of five equal bits, and all K.x.7 use it
  assign alt7 = (y3 == 3'd7) &&
                (k28 || kx7 ||
                 (!rd_mid && (x5 inside {5'd17, 5'd18, 5'd20})) ||
                 (rd_mid && (x5 inside {5'd11, 5'd13, 5'd14})));

  always_comb begin
    case (y3)
      3'd0:    code4_n = 4'b1011;
      3'd1:    code4_n = 4'b1001;
      3'd2:    code4_n = 4'b0101;
      3'd3:    code4_n = 4'b1100;
      3'd4:    code4_n = 4'b1101;
      3'd5:    code4_n = 4'b1010;
      3'd6:    code4_n = 4'b0110;
      default: code4_n = alt7 ? 4'b0111 : 4'b1110;
    endcase
  end

  // K28 also inverts its balanced fghj after a 110000 prefix
  assign flip4 = (($countones(code4_n) != 2) || (y3 == 3'd3)) ? rd_mid : (k28 && !rd_mid);
  assign code4 = flip4 ? ~code4_n : code4_n;

  always_ff @(posedge pclk) begin
    if (rst) begin
      tx_symbol <= `PHY_COMMA_RDN;
      rd_cur    <= 1'b0;
    end else begin
      tx_symbol <= {code6, code4};
      rd_cur    <= rd_in;
    end
  end

  // Table and disparity choice together keep every symbol near balance
  a_sym_balance: assert property (@(posedge pclk) disable iff (rst)
    $countones(tx_symbol) inside {4, 5, 6});

endmodule

`default_nettype wire

// File: source/dec_8b10b.sv
`default_nettype none

`include "phy_defs.svh"

module dec_8b10b (
  input  logic                   pclk,
  input  logic                   rst,
  input  logic [`PHY_SYM_W-1:0]   rx_symbol,
  output logic [`PHY_DATA_W-1:0]  rx_data,
  output logic                   rx_datak,
  output phy_pkg::rx_status_t    rx_status,
  output logic                   code_error
);

  // Running disparity before rx_symbol, 1 means positive
  logic       rd_pos;
  logic       rd_mid;
  logic       rd_next;
  logic [5:0] sym6;
  logic [3:0] sym4;
  logic [3:0] sym4_look;
  logic [4:0] x5;
  logic [2:0] y3;
  logic       v6;
  logic       v4;
  logic       bal6;
  logic       bal4;
  logic       k28;
  logic       kx7;
  logic       a7;
  logic       p7;
  logic       a7_bad;
  logic       p7_bad;
  logic       disp6_bad;
  logic       disp4_bad;
  logic       err_dec;
  logic       err_disp;

  assign sym6 = rx_symbol[9:4];
  assign sym4 = rx_symbol[3:0];
  assign k28  = (sym6 == 6'b001111) || (sym6 == 6'b110000);

  ////////////////////////////////////////////////////////////
  // Subcode lookup
  ////////////////////////////////////////////////////////////

  // Both disparity forms map to the same 5b value
  always_comb begin
    x5 = 5'd0;
    v6 = 1'b1;
    case (sym6)
      6'b100111, 6'b011000: x5 = 5'd0;
      6'b011101, 6'b100010: x5 = 5'd1;
      6'b101101, 6'b010010: x5 = 5'd2;
      6'b110001:            x5 = 5'd3;
      6'b110101, 6'b001010: x5 = 5'd4;
      6'b101001:            x5 = 5'd5;
      6'b011001:            x5 = 5'd6;
      6'b111000, 6'b000111: x5 = 5'd7;
      6'b111001, 6'b000110: x5 = 5'd8;
      6'b100101:            x5 = 5'd9;
      6'b010101:            x5 = 5'd10;
      6'b110100:            x5 = 5'd11;
      6'b001101:            x5 = 5'd12;
      6'b101100:            x5 = 5'd13;
      6'b011100:            x5 = 5'd14;
      6'b010111, 6'b101000: x5 = 5'd15;
      6'b011011, 6'b100100: x5 = 5'd16;
      6'b100011:            x5 = 5'd17;
      6'b010011:            x5 = 5'd18;
      6'b110010:            x5 = 5'd19;
      6'b001011:            x5 = 5'd20;
      6'b101010:            x5 = 5'd21;
      6'b011010:            x5 = 5'd22;
      6'b111010, 6'b000101: x5 = 5'd23;
      6'b110011, 6'b001100: x5 = 5'd24;
      6'b100110:            x5 = 5'd25;
      6'b010110:            x5 = 5'd26;
      6'b110110, 6'b001001: x5 = 5'd27;
      6'b001110:            x5 = 5'd28;
      6'b001111, 6'b110000: x5 = 5'd28;
      6'b101110, 6'b010001: x5 = 5'd29;
      6'b011110, 6'b100001: x5 = 5'd30;
      6'b101011, 6'b010100: x5 = 5'd31;
      default:              v6 = 1'b0;
    endcase
  end

  // K28 after 110000 carries an inverted fghj
  assign sym4_look = (sym6 == 6'b110000) ? ~sym4 : sym4;

  always_comb begin
    y3 = 3'd0;
    v4 = 1'b1;
    case (sym4_look)
      4'b1011, 4'b0100:                   y3 = 3'd0;
      4'b1001:                            y3 = 3'd1;
      4'b0101:                            y3 = 3'd2;
      4'b1100, 4'b0011:                   y3 = 3'd3;
      4'b1101, 4'b0010:                   y3 = 3'd4;
      4'b1010:                            y3 = 3'd5;
      4'b0110:                            y3 = 3'd6;
      4'b1110, 4'b0001, 4'b0111, 4'b1000: y3 = 3'd7;
      default:                            v4 = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Code and disparity checks
  ////////////////////////////////////////////////////////////

  assign bal6   = ($countones(sym6) == 3);
  assign rd_mid = bal6 ? rd_pos : ($countones(sym6) > 3);
  assign bal4   = ($countones(sym4) == 2);
  assign rd_next = bal4 ? rd_mid : ($countones(sym4) > 2);

  // Each subcode against the disparity in front of it
  assign disp6_bad = (!bal6 && (rd_pos == ($countones(sym6) > 3))) ||
                     ((sym6 == 6'b111000) && rd_pos) ||
                     ((sym6 == 6'b000111) && !rd_pos);
  assign disp4_bad = (!bal4 && (rd_mid == ($countones(sym4) > 2))) ||
                     ((sym4 == 4'b1100) && rd_mid) ||
                     ((sym4 == 4'b0011) && !rd_mid);

  // A7 only where the encoder would pick it, P7 never there
  assign a7     = (sym4 == 4'b0111) || (sym4 == 4'b1000);
  assign p7     = (sym4 == 4'b1110) || (sym4 == 4'b0001);
  assign kx7    = a7 && (x5 inside {5'd23, 5'd27, 5'd29, 5'd30});
  assign a7_bad = a7 && !(k28 || kx7 ||
                          (x5 inside {5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20}));
  assign p7_bad = p7 && (k28 ||
                         (!rd_mid && (x5 inside {5'd17, 5'd18, 5'd20})) ||
                         (rd_mid && (x5 inside {5'd11, 5'd13, 5'd14})));

  assign err_dec  = !v6 || !v4 || a7_bad || p7_bad;
  assign err_disp = disp6_bad || disp4_bad;

  always_ff @(posedge pclk) begin
    if (rst) begin
      rx_data   <= '0;
      rx_datak  <= 1'b0;
      rx_status <= phy_pkg::rx_ok;
      rd_pos    <= 1'b0;
    end else begin
      // Disparity keeps following the line even through bad symbols
      rd_pos <= rd_next;
      if (err_dec) begin
        rx_data   <= `PHY_K28_5;
        rx_datak  <= 1'b0;
        rx_status <= phy_pkg::rx_decode_err;
      end else if (err_disp) begin
        rx_data   <= `PHY_K28_5;
        rx_datak  <= 1'b0;
        rx_status <= phy_pkg::rx_disp_err;
      end else begin
        rx_data   <= {y3, x5};
        rx_datak  <= k28 || kx7;
        rx_status <= phy_pkg::rx_ok;
      end
    end
  end

  assign code_error = (rx_status != phy_pkg::rx_ok);

  a_status_legal: assert property (@(posedge pclk) disable iff (rst)
    rx_status inside {phy_pkg::rx_ok, phy_pkg::rx_decode_err, phy_pkg::rx_disp_err});

endmodule

`default_nettype wire

// File: source/comma_detect.sv
`default_nettype none

`include "phy_defs.svh"

module comma_detect (
  input  logic                 pclk,
  input  logic                 rst,
  input  logic [`PHY_SYM_W-1:0] rx_symbol,
  input  logic                 code_error,
  output logic                 comma_pulse,
  output logic                 rx_valid
);

  localparam int CNT_W = $clog2(`PHY_COMMA_COUNT + 1);

  // Count saturates once alignment is reached
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`PHY_COMMA_COUNT);
  // Value seen just before the last comma of a run
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PHY_COMMA_COUNT - 1);

  logic [CNT_W-1:0] comma_cnt;
  logic             is_comma;

  // K28.5 in either disparity
  assign is_comma = (rx_symbol == `PHY_COMMA_RDN) || (rx_symbol == `PHY_COMMA_RDP);

  ////////////////////////////////////////////////////////////
  // Alignment FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      comma_cnt   <= '0;
      comma_pulse <= 1'b0;
      rx_valid    <= 1'b0;
    end else begin
      comma_pulse <= is_comma;
      if (code_error) begin
        // Lost lock, start over with a fresh run
        comma_cnt <= '0;
        rx_valid  <= 1'b0;
      end else if (is_comma) begin
        if (comma_cnt != CNT_FULL) begin
          comma_cnt <= comma_cnt + 1'b1;
        end
        if (comma_cnt == CNT_LAST) begin
          rx_valid <= 1'b1;
        end
      end else begin
        // Data breaks the run but keeps an existing lock
        comma_cnt <= '0;
      end
    end
  end

  // Lock only ever starts on a comma
  a_valid_on_comma: assert property (@(posedge pclk) disable iff (rst)
    $rose(rx_valid) |-> comma_pulse);

endmodule

`default_nettype wire

// File: source/pcs_rx.sv
`default_nettype none

`include "phy_defs.svh"

module pcs_rx (
  input  logic                   pclk,
  input  logic                   rst,
  input  logic [`PHY_SYM_W-1:0]   rx_symbol,
  input  logic                   rx_polarity,
  output logic [`PHY_DATA_W-1:0]  rx_data,
  output logic                   rx_datak,
  output phy_pkg::rx_status_t    rx_status,
  output logic                   rx_valid
);

  // Symbol after polarity fix
  logic [`PHY_SYM_W-1:0] sym_fixed;
  logic                  code_error;
  // Monitor point for the testbench
  logic                  comma_pulse;

  // Swapped differential pair shows up as every bit inverted
  assign sym_fixed = rx_polarity ? ~rx_symbol : rx_symbol;

  ////////////////////////////////////////////////////////////
  // Alignment and decode
  ////////////////////////////////////////////////////////////

  comma_detect comma_detect_i (
    .pclk       (pclk),
    .rst        (rst),
    .rx_symbol  (sym_fixed),
    .code_error (code_error),
    .comma_pulse(comma_pulse),
    .rx_valid   (rx_valid)
  );

  dec_8b10b dec_8b10b_i (
    .pclk      (pclk),
    .rst       (rst),
    .rx_symbol (sym_fixed),
    .rx_data   (rx_data),
    .rx_datak  (rx_datak),
    .rx_status (rx_status),
    .code_error(code_error)
  );

endmodule

`default_nettype wire

// File: source/phy_pcs.sv
`default_nettype none

`include "phy_defs.svh"

module phy_pcs (
  input  logic                   pclk,
  input  logic                   rst,
  // MAC transmit side
  input  logic [`PHY_DATA_W-1:0]  tx_data,
  input  logic                   tx_datak,
  input  logic                   tx_en,
  // Line side
  input  logic [`PHY_SYM_W-1:0]   rx_symbol,
  input  logic                   rx_polarity,
  output logic [`PHY_SYM_W-1:0]   tx_symbol,
  // MAC receive side
  output logic [`PHY_DATA_W-1:0]  rx_data,
  output logic                   rx_datak,
  output phy_pkg::rx_status_t    rx_status,
  output logic                   rx_valid
);

  ////////////////////////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////////////////////////

  enc_8b10b enc_8b10b_i (
    .pclk     (pclk),
    .rst      (rst),
    .tx_data  (tx_data),
    .tx_datak (tx_datak),
    .tx_en    (tx_en),
    .tx_symbol(tx_symbol)
  );

  ////////////////////////////////////////////////////////////
  // Receive
  ////////////////////////////////////////////////////////////

  pcs_rx pcs_rx_i (
    .pclk       (pclk),
    .rst        (rst),
    .rx_symbol  (rx_symbol),
    .rx_polarity(rx_polarity),
    .rx_data    (rx_data),
    .rx_datak   (rx_datak),
    .rx_status  (rx_status),
    .rx_valid   (rx_valid)
  );

endmodule

`default_nettype wire

// File: test/phy_tb.sv
`default_nettype none

`include "phy_defs.svh"

module phy_tb;

  localparam int RUN_LEN  = 200;
  localparam int WAIT_MAX = 64;

  logic                   pclk;
  logic                   rst;
  logic [`PHY_DATA_W-1:0] tx_data;
  logic                   tx_datak;
  logic                   tx_en;
  logic [`PHY_SYM_W-1:0]  rx_symbol;
  logic                   rx_polarity;
  logic [`PHY_SYM_W-1:0]  tx_symbol;
  logic [`PHY_DATA_W-1:0] rx_data;
  logic                   rx_datak;
  phy_pkg::rx_status_t    rx_status;
  logic                   rx_valid;

  // Loopback controls
  logic                   invert;
  logic                   flip_arm;
  logic [3:0]             flip_bit;
  logic [`PHY_SYM_W-1:0]  flip_mask;
  // Line after the receiver's polarity fix
  logic [`PHY_SYM_W-1:0]  line_fixed;
  // Comma seen on the fixed line at the previous edge
  logic                   line_comma_d1;
  logic                   fault_d1;
  logic                   rst_seen;

  // Reference state, {en, k, byte} per cycle
  logic [15:0]            lfsr;
  logic [`PHY_DATA_W+1:0] sent_q[$];
  logic [`PHY_DATA_W+1:0] exp_word;
  int                     clean_commas;
  // Running digital sum before tx_symbol and after its 6b part
  int                     rds;
  int                     rds_mid;
  int                     errors;
  int                     timeouts;

  phy_pcs phy_pcs_i (
    .pclk       (pclk),
    .rst        (rst),
    .tx_data    (tx_data),
    .tx_datak   (tx_datak),
    .tx_en      (tx_en),
    .rx_symbol  (rx_symbol),
    .rx_polarity(rx_polarity),
    .tx_symbol  (tx_symbol),
    .rx_data    (rx_data),
    .rx_datak   (rx_datak),
    .rx_status  (rx_status),
    .rx_valid   (rx_valid)
  );

  always #10 pclk = ~pclk;

  ////////////////////////////////////////////////////////////
  // Loopback with fault injection
  ////////////////////////////////////////////////////////////

  assign flip_mask  = flip_arm ? (`PHY_SYM_W'(1) << flip_bit) : '0;
  assign rx_symbol  = (invert ? ~tx_symbol : tx_symbol) ^ flip_mask;
  assign line_fixed = rx_polarity ? ~rx_symbol : rx_symbol;
  assign rds_mid    = rds + 2 * $countones(tx_symbol[9:4]) - 6;

  always @(posedge pclk) begin
    rst_seen <= rst;
    fault_d1 <= flip_arm;
    if (rst) begin
      sent_q.delete();
      exp_word      <= '0;
      clean_commas  <= 0;
      line_comma_d1 <= 1'b0;
      // Line starts at negative disparity
      rds           <= -1;
    end else begin
      // Word sampled now comes back two edges later
      sent_q.push_back({tx_en, tx_datak, tx_data});
      if (sent_q.size() > 1) begin
        exp_word <= sent_q.pop_front();
      end
      line_comma_d1 <= (line_fixed == `PHY_COMMA_RDN || line_fixed == `PHY_COMMA_RDP);
      // Commas since the last error or data symbol
      if (rx_status != phy_pkg::rx_ok) begin
        clean_commas <= 0;
      end else if (line_fixed == `PHY_COMMA_RDN || line_fixed == `PHY_COMMA_RDP) begin
        if (clean_commas < `PHY_COMMA_COUNT) begin
          clean_commas <= clean_commas + 1;
        end
      end else begin
        clean_commas <= 0;
      end
      rds <= rds + 2 * $countones(tx_symbol) - 10;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge pclk)
    rst_seen |-> (!rx_valid && rx_status == phy_pkg::rx_ok && rx_data == '0 &&
                  !rx_datak && tx_symbol == `PHY_COMMA_RDN))
    else begin
      errors++;
      $display("Mismatch at %0t: outputs not at reset values", $time);
    end

  // Lock comes exactly with the last comma of a clean run
  a_valid_rise: assert property (@(posedge pclk) disable iff (rst)
    $rose(rx_valid) |-> (clean_commas == `PHY_COMMA_COUNT))
    else begin
      errors++;
      $display("Mismatch at %0t: rx_valid rose after %0d commas", $time, clean_commas);
    end

  a_valid_full: assert property (@(posedge pclk) disable iff (rst)
    (clean_commas == `PHY_COMMA_COUNT) |-> rx_valid)
    else begin
      errors++;
      $display("Mismatch at %0t: rx_valid low after a full comma run", $time);
    end

  a_valid_hold: assert property (@(posedge pclk) disable iff (rst)
    (rx_valid && rx_status == phy_pkg::rx_ok) |=> rx_valid)
    else begin
      errors++;
      $display("Mismatch at %0t: rx_valid dropped without an error", $time);
    end

  // Registered pulse inside the receive path, one per comma on the line
  a_comma_pulse: assert property (@(posedge pclk) disable iff (rst)
    phy_pcs_i.pcs_rx_i.comma_pulse == line_comma_d1)
    else begin
      errors++;
      $display("Mismatch at %0t: comma pulse %b, expected %b", $time,
               phy_pcs_i.pcs_rx_i.comma_pulse, line_comma_d1);
    end

  a_round_trip: assert property (@(posedge pclk) disable iff (rst)
    exp_word[9] |-> (rx_data == exp_word[7:0] && rx_datak == exp_word[8] &&
                     rx_status == phy_pkg::rx_ok))
    else begin
      errors++;
      $display("Mismatch at %0t: got %h k=%b status=%0d, expected %h k=%b", $time,
               rx_data, rx_datak, rx_status, exp_word[7:0], exp_word[8]);
    end

  a_ones: assert property (@(posedge pclk) disable iff (rst)
    $countones(tx_symbol) inside {4, 5, 6})
    else begin
      errors++;
      $display("Mismatch at %0t: tx_symbol %b has %0d ones", $time, tx_symbol,
               $countones(tx_symbol));
    end

  a_disparity: assert property (@(posedge pclk) disable iff (rst)
    (rds == -1 || rds == 1) && (rds_mid == -1 || rds_mid == 1))
    else begin
      errors++;
      $display("Mismatch at %0t: running sum %0d, after 6b %0d", $time, rds, rds_mid);
    end

  a_fault_status: assert property (@(posedge pclk) disable iff (rst)
    flip_arm |=> (rx_status != phy_pkg::rx_ok))
    else begin
      errors++;
      $display("Mismatch at %0t: corrupted symbol passed as ok", $time);
    end

  a_fault_drop: assert property (@(posedge pclk) disable iff (rst)
    fault_d1 |=> !rx_valid)
    else begin
      errors++;
      $display("Mismatch at %0t: rx_valid still high after an error", $time);
    end

  // Clean line never reports an error
  a_status_cause: assert property (@(posedge pclk) disable iff (rst)
    (rx_status != phy_pkg::rx_ok) |-> fault_d1)
    else begin
      errors++;
      $display("Mismatch at %0t: status %0d on a clean line", $time, rx_status);
    end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  // The twelve legal K bytes, K28.y repeats for the top indices
  function automatic logic [7:0] k_byte(input logic [3:0] idx);
    case (idx)
      4'd8:    return 8'hF7;
      4'd9:    return 8'hFB;
      4'd10:   return 8'hFD;
      4'd11:   return 8'hFE;
      default: return {idx[2:0], 5'd28};
    endcase
  endfunction

  task automatic send_random(input int count);
    logic [7:0] pick;
    for (int n = 0; n < count; n++) begin
      @(posedge pclk);
      draw_bits(3, pick);
      tx_en <= 1'b1;
      // About one K code in eight
      if (pick[2:0] == 3'd0) begin
        draw_bits(4, pick);
        tx_data  <= k_byte(pick[3:0]);
        tx_datak <= 1'b1;
      end else begin
        draw_bits(8, pick);
        tx_data  <= pick;
        tx_datak <= 1'b0;
      end
    end
  endtask

  task automatic send_idle(input int count);
    @(posedge pclk);
    tx_en    <= 1'b0;
    tx_datak <= 1'b0;
    tx_data  <= '0;
    repeat (count - 1) @(posedge pclk);
  endtask

  // Bit 9 or 8 of either comma leaves a 6b part with one or five ones
  task automatic inject_flip();
    logic [7:0] pick;
    draw_bits(1, pick);
    @(posedge pclk);
    flip_bit <= {3'b100, pick[0]};
    flip_arm <= 1'b1;
    @(posedge pclk);
    flip_arm <= 1'b0;
  endtask

  task automatic finish_run();
    $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic wait_valid(input logic level, input int limit, output logic ok);
    int n;
    n = 0;
    while (rx_valid !== level && n < limit) begin
      @(posedge pclk);
      n++;
    end
    ok = (rx_valid === level);
    if (!ok) begin
      timeouts++;
      $display("Timeout at %0t: rx_valid did not go to %0b within %0d cycles",
               $time, level, limit);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  task automatic run_sequence();
    logic ok;
    // Idle commas bring up alignment
    wait_valid(1'b1, WAIT_MAX, ok);
    if (!ok) begin
      return;
    end
    send_idle(8);
    send_random(RUN_LEN);
    send_idle(8);

    // Swapped pair on the line, undone by rx_polarity
    @(posedge pclk);
    invert      <= 1'b1;
    rx_polarity <= 1'b1;
    send_random(RUN_LEN);
    send_idle(8);
    inject_flip();
    wait_valid(1'b0, WAIT_MAX, ok);
    if (!ok) begin
      return;
    end
    wait_valid(1'b1, WAIT_MAX, ok);
    if (!ok) begin
      return;
    end

    // Straight line again, error then data after relock
    @(posedge pclk);
    invert      <= 1'b0;
    rx_polarity <= 1'b0;
    send_idle(4);
    inject_flip();
    wait_valid(1'b0, WAIT_MAX, ok);
    if (!ok) begin
      return;
    end
    wait_valid(1'b1, WAIT_MAX, ok);
    if (!ok) begin
      return;
    end
    send_random(RUN_LEN / 2);
    send_idle(8);
  endtask

  initial begin
    pclk        = 1'b0;
    rst         = 1'b1;
    tx_data     = '0;
    tx_datak    = 1'b0;
    tx_en       = 1'b0;
    rx_polarity = 1'b0;
    invert      = 1'b0;
    flip_arm    = 1'b0;
    flip_bit    = 4'd0;
    rst_seen    = 1'b0;
    fault_d1    = 1'b0;
    lfsr        = 16'd61;
    errors      = 0;
    timeouts    = 0;
    repeat (2) @(posedge pclk);
    rst <= 1'b0;
    run_sequence();
    finish_run();
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/phy_pkg.sv
source/enc_8b10b.sv
source/dec_8b10b.sv
source/comma_detect.sv
source/pcs_rx.sv
source/phy_pcs.sv
test/phy_tb.sv

// File: Makefile
# Verilator build and run for the PCS testbench

VERILATOR ?= verilator
TOP       ?= phy_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= TB PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
